// ==== flist.f ====
verilog/sprite_pkg.sv
verilog/sprite_attr_if.sv
verilog/sprite_bitmap_ram.sv
verilog/sprite_attr_regs.sv
verilog/sprite_unit.sv
verilog/sprite_mixer.sv
verilog/sprite_engine_top.sv
test/tb_clk_gen.sv
test/tb_sprite_engine.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
   --top-module tb_sprite_engine -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Test OK" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

// free-running clock for the testbench
module tb_clk_gen (
   output logic clk
);

   localparam real HALF_PERIOD = 2.0;   // 4 ns period

   initial begin
      clk = 1'b0;
      forever begin
         #(HALF_PERIOD) clk = ~clk;
      end
   end

endmodule

// ==== test/tb_sprite_engine.sv ====
`timescale 1ns/1ps

module tb_sprite_engine import sprite_pkg::*; ();

   localparam int          RESET_CYCLES = 16;
   localparam int          RAND_QUERIES = 200;
   localparam logic [31:0] RAND_SEED    = 32'h6e03_19df;

   // one row of the stimulus table, a host write, a query or nothing
   typedef struct packed {
      logic       is_write;
      logic       is_query;
      wr_target_e target;
      sprite_id_t unit;
      bmp_addr_t  addr;
      logic       data;
      coord_t     x;
      coord_t     y;
      logic       exp_hit;
      sprite_id_t exp_id;
   } step_t;

   logic       clk;
   logic       arst_n;
   logic       wr_en;
   wr_target_e wr_target;
   sprite_id_t wr_unit;
   bmp_addr_t  wr_addr;
   logic       wr_data;
   logic       q_valid;
   coord_t     q_x;
   coord_t     q_y;
   logic       out_valid;
   logic       out_hit;
   sprite_id_t out_id;

   step_t steps [$];
   string names [$];

   // expected sprite state, follows the table as it is built
   coord_t                   ref_x    [NUM_SPRITES];
   coord_t                   ref_y    [NUM_SPRITES];
   bmp_addr_t                ref_base [NUM_SPRITES];
   logic                     ref_en   [NUM_SPRITES];
   logic [2**BMP_ADDR_W-1:0] ref_bmp  [NUM_SPRITES];

   int cycles      = 0;
   int cycle_limit = 0;   // set once the table length is known

   tb_clk_gen clk_gen0 (.clk (clk));

   sprite_engine_top dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .wr_en     (wr_en),
      .wr_target (wr_target),
      .wr_unit   (wr_unit),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .q_valid   (q_valid),
      .q_x       (q_x),
      .q_y       (q_y),
      .out_valid (out_valid),
      .out_hit   (out_hit),
      .out_id    (out_id)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         report_failure($sformatf("Error: %s out_valid expected %0b actual %0b", name, exp, act));
      end
   endtask

   task automatic check_hit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         report_failure($sformatf("Error: %s out_hit expected %0b actual %0b", name, exp, act));
      end
   endtask

   task automatic check_id(input string name, input sprite_id_t exp, input sprite_id_t act);
      if (act !== exp) begin
         report_failure($sformatf("Error: %s out_id expected %0d actual %0d", name, exp, act));
      end
   endtask

   // coverage rule, then lowest index with a set bitmap bit wins
   task automatic predict_pixel(input coord_t x, input coord_t y,
                                output logic hit, output sprite_id_t id);
      int        dx;
      int        dy;
      logic      inside_box;
      bmp_addr_t a;
      hit = 1'b0;
      id  = '0;
      for (int i = 0; i < NUM_SPRITES; i++) begin
         dx = int'(x) - int'(ref_x[i]);
         dy = int'(y) - int'(ref_y[i]);
         inside_box = (dx >= 0) && (dx < SPRITE_DIM) && (dy >= 0) && (dy < SPRITE_DIM);
         a = bmp_addr_t'(int'(ref_base[i]) + SPRITE_DIM * dy + dx);
         if (!hit && ref_en[i] && inside_box && ref_bmp[i][a]) begin
            hit = 1'b1;
            id  = sprite_id_t'(i);
         end
      end
   endtask

   task automatic push_write(input string name, input wr_target_e tgt, input int unit,
                             input int addr, input logic data);
      step_t     s;
      bmp_addr_t a;
      a = bmp_addr_t'(addr);
      s = '0;
      s.is_write = 1'b1;
      s.target   = tgt;
      s.unit     = sprite_id_t'(unit);
      s.addr     = a;
      s.data     = data;
      steps.push_back(s);
      names.push_back(name);
      case (tgt)
         TGT_X:      ref_x[unit]    = a[COORD_W-1:0];
         TGT_Y:      ref_y[unit]    = a[COORD_W-1:0];
         TGT_BASE:   ref_base[unit] = a;
         TGT_ENABLE: ref_en[unit]   = a[0];
         default: begin
            if (a != NULL_ADDR) ref_bmp[unit][a] = data;   // null entry never changes
         end
      endcase
   endtask

   task automatic expect_query(input string name, input int x, input int y,
                               input logic hit, input int id);
      step_t s;
      s = '0;
      s.is_query = 1'b1;
      s.x        = coord_t'(x);
      s.y        = coord_t'(y);
      s.exp_hit  = hit;
      s.exp_id   = sprite_id_t'(id);
      steps.push_back(s);
      names.push_back(name);
   endtask

   // random point near one of the four boxes, edges included
   task automatic random_query(input string name);
      int         pick;
      coord_t     x;
      coord_t     y;
      logic       hit;
      sprite_id_t id;
      pick = int'($urandom % NUM_SPRITES);
      x = coord_t'(int'(ref_x[pick]) - 4 + int'($urandom % 24));
      y = coord_t'(int'(ref_y[pick]) - 4 + int'($urandom % 24));
      predict_pixel(x, y, hit, id);
      expect_query(name, int'(x), int'(y), hit, int'(id));
   endtask

   task automatic build_table();
      int px [NUM_SPRITES] = '{100, 108, 300, 400};
      int py [NUM_SPRITES] = '{50, 58, 200, 300};
      int pb [NUM_SPRITES] = '{16, 512, 1024, 0};   // sprite 3 starts on the null entry
      for (int i = 0; i < NUM_SPRITES; i++) begin
         push_write("place x", TGT_X, i, px[i], 1'b0);
         push_write("place y", TGT_Y, i, py[i], 1'b0);
         push_write("set base", TGT_BASE, i, pb[i], 1'b0);
      end
      // checkerboard, solid, upper triangle, solid including address 0
      for (int r = 0; r < SPRITE_DIM; r++) begin
         for (int c = 0; c < SPRITE_DIM; c++) begin
            if ((r + c) % 2 == 0) push_write("s0 bitmap", TGT_BITMAP, 0, 16 + 16 * r + c, 1'b1);
            push_write("s1 bitmap", TGT_BITMAP, 1, 512 + 16 * r + c, 1'b1);
            if (c >= r) push_write("s2 bitmap", TGT_BITMAP, 2, 1024 + 16 * r + c, 1'b1);
            push_write("s3 bitmap", TGT_BITMAP, 3, 16 * r + c, 1'b1);
         end
      end
      expect_query("no enable s0", 100, 50, 1'b0, 0);
      expect_query("no enable s3", 401, 300, 1'b0, 0);
      for (int i = 0; i < NUM_SPRITES; i++) begin
         push_write("enable", TGT_ENABLE, i, 1, 1'b0);
      end
      expect_query("s0 set bit", 100, 50, 1'b1, 0);
      expect_query("s0 clear bit", 101, 50, 1'b0, 0);
      expect_query("left of s0", 99, 50, 1'b0, 0);
      expect_query("overlap both set", 110, 60, 1'b1, 0);
      expect_query("overlap s0 corner", 115, 65, 1'b1, 0);
      expect_query("overlap s0 clear", 111, 60, 1'b1, 1);
      expect_query("s1 only", 120, 70, 1'b1, 1);
      expect_query("s1 far corner", 123, 73, 1'b1, 1);
      expect_query("right of s1", 124, 73, 1'b0, 0);
      expect_query("below s1", 123, 74, 1'b0, 0);
      expect_query("s2 diagonal", 305, 205, 1'b1, 2);
      expect_query("s2 below diagonal", 304, 205, 1'b0, 0);
      expect_query("s3 inner", 401, 300, 1'b1, 3);
      expect_query("s3 null entry", 400, 300, 1'b0, 0);
      push_write("disable s0", TGT_ENABLE, 0, 0, 1'b0);
      expect_query("s0 off overlap", 110, 60, 1'b1, 1);
      expect_query("s0 off origin", 100, 50, 1'b0, 0);
      push_write("enable s0 again", TGT_ENABLE, 0, 1, 1'b0);
      expect_query("s0 back", 100, 50, 1'b1, 0);
      for (int n = 0; n < RAND_QUERIES; n++) begin
         random_query($sformatf("random %0d", n));
      end
   endtask

   task automatic apply_step(input step_t s);
      wr_en     = s.is_write;
      wr_target = s.target;
      wr_unit   = s.unit;
      wr_addr   = s.addr;
      wr_data   = s.data;
      q_valid   = s.is_query;
      q_x       = s.x;
      q_y       = s.y;
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if ((cycle_limit > 0) && (cycles > cycle_limit)) begin
         report_failure($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
      end
   end

   initial begin
      step_t cur;
      step_t p0;          // query driven one edge ago
      step_t p1;          // query driven two edges ago, result due now
      string cur_name;
      string p0_name;
      string p1_name;
      apply_step('0);
      arst_n = 1'b0;
      void'($urandom(RAND_SEED));
      for (int i = 0; i < NUM_SPRITES; i++) begin
         ref_x[i]    = '0;
         ref_y[i]    = '0;
         ref_base[i] = '0;
         ref_en[i]   = 1'b0;
         ref_bmp[i]  = '0;
      end
      build_table();
      cycle_limit = RESET_CYCLES + steps.size() + 64;
      p0 = '0;
      p1 = '0;
      p0_name = "reset";
      p1_name = "reset";
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      for (int k = 0; k < steps.size() + 2; k++) begin
         @(negedge clk);
         if (p1.is_query) begin
            check_valid(p1_name, 1'b1, out_valid);
            check_hit(p1_name, p1.exp_hit, out_hit);
            check_id(p1_name, p1.exp_id, out_id);
         end else begin
            check_valid(p1_name, 1'b0, out_valid);   // nothing issued, stays idle
         end
         if (k < steps.size()) begin
            cur      = steps[k];
            cur_name = names[k];
         end else begin
            cur      = '0;
            cur_name = "drain";
         end
         apply_step(cur);
         p1      = p0;
         p1_name = p0_name;
         p0      = cur;
         p0_name = cur_name;
      end
      $display("Test OK");
      $finish;
   end

endmodule

// ==== verilog/sprite_attr_if.sv ====
`timescale 1ns/1ps

// attributes of one sprite, held in the register block and read by its unit
interface sprite_attr_if import sprite_pkg::*; ();

   coord_t    x_pos;    // left edge
   coord_t    y_pos;    // top edge
   bmp_addr_t base;     // first bitmap entry of the sprite
   enable_t   enable;

   modport src (
      output x_pos,
      output y_pos,
      output base,
      output enable
   );

   modport dst (
      input  x_pos,
      input  y_pos,
      input  base,
      input  enable
   );

endinterface

// ==== verilog/sprite_attr_regs.sv ====
`timescale 1ns/1ps

module sprite_attr_regs import sprite_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   wr_en,
   input  wr_target_e             wr_target,
   input  sprite_id_t             wr_unit,
   input  bmp_addr_t              wr_addr,
   input  logic                   wr_data,
   sprite_attr_if.src             attr [NUM_SPRITES],
   output logic [NUM_SPRITES-1:0] bmp_wr_en,
   output bmp_addr_t              bmp_wr_addr,
   output logic                   bmp_wr_data
);

   logic [NUM_SPRITES-1:0] unit_sel;     // one-hot of wr_unit
   logic                   do_x;
   logic                   do_y;
   logic                   do_base;
   logic                   do_enable;
   logic                   do_bitmap;

   coord_t                 x_q    [NUM_SPRITES];
   coord_t                 y_q    [NUM_SPRITES];
   bmp_addr_t              base_q [NUM_SPRITES];
   enable_t                enable_q [NUM_SPRITES];

   always_comb begin
      unit_sel = '0;
      unit_sel[wr_unit] = 1'b1;
   end

   assign do_x      = wr_en && (wr_target == TGT_X);
   assign do_y      = wr_en && (wr_target == TGT_Y);
   assign do_base   = wr_en && (wr_target == TGT_BASE);
   assign do_enable = wr_en && (wr_target == TGT_ENABLE);
   assign do_bitmap = wr_en && (wr_target == TGT_BITMAP);

   // position and base, wr_addr doubles as the data field
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_SPRITES; i++) begin
         if (unit_sel[i]) begin
            if (do_x)    x_q[i]    <= wr_addr[COORD_W-1:0];
            if (do_y)    y_q[i]    <= wr_addr[COORD_W-1:0];
            if (do_base) base_q[i] <= wr_addr;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_SPRITES; i++) begin
            enable_q[i] <= '0;
         end
      end else if (do_enable) begin
         for (int i = 0; i < NUM_SPRITES; i++) begin
            if (unit_sel[i]) enable_q[i] <= wr_addr[ENABLE_W-1:0];
         end
      end
   end

   // bitmap writes go straight to the selected unit's memory
   assign bmp_wr_en   = do_bitmap ? unit_sel : '0;
   assign bmp_wr_addr = wr_addr;
   assign bmp_wr_data = wr_data;

   for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_attr
      assign attr[g].x_pos  = x_q[g];
      assign attr[g].y_pos  = y_q[g];
      assign attr[g].base   = base_q[g];
      assign attr[g].enable = enable_q[g];
   end

endmodule

// ==== verilog/sprite_bitmap_ram.sv ====
`timescale 1ns/1ps

module sprite_bitmap_ram import sprite_pkg::*; (
   input  logic      clk,
   input  logic      rd_en,
   input  bmp_addr_t rd_addr,
   output logic      rd_data,
   input  logic      wr_en,
   input  bmp_addr_t wr_addr,
   input  logic      wr_data
);

   localparam int DEPTH = 2 ** BMP_ADDR_W;

   // one bit per pixel, all clear at power up
   logic mem [DEPTH] = '{default: 1'b0};

   // write port, entry 0 stays the null sprite
   always_ff @(posedge clk) begin
      if (wr_en && (wr_addr != NULL_ADDR)) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, old data on a same-address write
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

// ==== verilog/sprite_engine_top.sv ====
`timescale 1ns/1ps

module sprite_engine_top import sprite_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,

   // host write port, one-cycle strobe
   input  logic       wr_en,
   input  wr_target_e wr_target,
   input  sprite_id_t wr_unit,
   input  bmp_addr_t  wr_addr,
   input  logic       wr_data,

   // pixel query, answered two cycles later
   input  logic       q_valid,
   input  coord_t     q_x,
   input  coord_t     q_y,

   output logic       out_valid,
   output logic       out_hit,
   output sprite_id_t out_id
);

   logic [NUM_SPRITES-1:0] bmp_wr_en;
   bmp_addr_t              bmp_wr_addr;
   logic                   bmp_wr_data;
   logic [NUM_SPRITES-1:0] unit_valid;
   logic [NUM_SPRITES-1:0] unit_pix;

   sprite_attr_if attr_bus [NUM_SPRITES] ();

   sprite_attr_regs u_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .wr_en       (wr_en),
      .wr_target   (wr_target),
      .wr_unit     (wr_unit),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .attr        (attr_bus),
      .bmp_wr_en   (bmp_wr_en),
      .bmp_wr_addr (bmp_wr_addr),
      .bmp_wr_data (bmp_wr_data)
   );

   // query is broadcast, each unit gets its own attributes and write enable
   for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_unit
      sprite_unit u_unit (
         .clk         (clk),
         .arst_n      (arst_n),
         .attr        (attr_bus[g]),
         .q_valid     (q_valid),
         .q_x         (q_x),
         .q_y         (q_y),
         .bmp_wr_en   (bmp_wr_en[g]),
         .bmp_wr_addr (bmp_wr_addr),
         .bmp_wr_data (bmp_wr_data),
         .unit_valid  (unit_valid[g]),
         .unit_pix    (unit_pix[g])
      );
   end

   sprite_mixer u_mixer (
      .clk        (clk),
      .arst_n     (arst_n),
      .unit_valid (unit_valid),
      .unit_pix   (unit_pix),
      .out_valid  (out_valid),
      .out_hit    (out_hit),
      .out_id     (out_id)
   );

endmodule

// ==== verilog/sprite_mixer.sv ====
`timescale 1ns/1ps

module sprite_mixer import sprite_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic [NUM_SPRITES-1:0] unit_valid,
   input  logic [NUM_SPRITES-1:0] unit_pix,
   output logic                   out_valid,
   output logic                   out_hit,
   output sprite_id_t             out_id
);

   logic [NUM_SPRITES-1:0] pix_set;     // units reporting a set pixel
   logic                   sel_hit;
   sprite_id_t             sel_id;

   assign pix_set = unit_valid & unit_pix;

   // walk from the top so the lowest index is written last and wins
   always_comb begin
      sel_hit = 1'b0;
      sel_id  = '0;
      for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
         if (pix_set[i]) begin
            sel_hit = 1'b1;
            sel_id  = sprite_id_t'(i);
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
         out_hit   <= 1'b0;
         out_id    <= '0;
      end else begin
         out_valid <= |unit_valid;   // units run in lockstep
         out_hit   <= sel_hit;
         out_id    <= sel_id;        // 0 when nothing hits
      end
   end

endmodule

// ==== verilog/sprite_pkg.sv ====
package sprite_pkg;

   // engine sizes
   localparam int NUM_SPRITES = 4;
   localparam int SPRITE_ID_W = 2;        // log2 of NUM_SPRITES
   localparam int COORD_W     = 10;       // screen coordinate, 0..1023
   localparam int SPRITE_DIM  = 16;       // sprites are 16x16 pixels
   localparam int BMP_ADDR_W  = 14;       // 16K one-bit entries per unit

   // attribute field widths
   localparam int OFFS_W      = 4;        // row or column offset inside a sprite
   localparam int ENABLE_W    = 1;

   typedef logic [COORD_W-1:0]     coord_t;
   typedef logic [BMP_ADDR_W-1:0]  bmp_addr_t;
   typedef logic [SPRITE_ID_W-1:0] sprite_id_t;
   typedef logic [ENABLE_W-1:0]    enable_t;

   // address 0 holds the null sprite and always reads 0
   localparam bmp_addr_t NULL_ADDR = '0;

   // host write target, carried on wr_target
   typedef enum logic [2:0] {
      TGT_X      = 3'd0,   // x position, low COORD_W bits of wr_addr
      TGT_Y      = 3'd1,   // y position, low COORD_W bits of wr_addr
      TGT_BASE   = 3'd2,   // bitmap base, whole wr_addr
      TGT_ENABLE = 3'd3,   // enable, bit 0 of wr_addr
      TGT_BITMAP = 3'd4    // bitmap bit wr_data at wr_addr
   } wr_target_e;

endpackage

// ==== verilog/sprite_unit.sv ====
`timescale 1ns/1ps

module sprite_unit import sprite_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   sprite_attr_if.dst attr,
   input  logic      q_valid,
   input  coord_t    q_x,
   input  coord_t    q_y,
   input  logic      bmp_wr_en,
   input  bmp_addr_t bmp_wr_addr,
   input  logic      bmp_wr_data,
   output logic      unit_valid,
   output logic      unit_pix
);

   coord_t              dx;        // query relative to the left edge
   coord_t              dy;        // query relative to the top edge
   logic                in_x;
   logic                in_y;
   logic                hit;
   logic [OFFS_W-1:0]   col;
   logic [OFFS_W-1:0]   row;
   bmp_addr_t           pix_offs;
   bmp_addr_t           rd_addr;

   assign dx = q_x - attr.x_pos;
   assign dy = q_y - attr.y_pos;

   // the >= test catches wrap-around of the subtraction
   assign in_x = (q_x >= attr.x_pos) && (dx < coord_t'(SPRITE_DIM));
   assign in_y = (q_y >= attr.y_pos) && (dy < coord_t'(SPRITE_DIM));
   assign hit  = attr.enable[0] && in_x && in_y;

   assign col = dx[OFFS_W-1:0];
   assign row = dy[OFFS_W-1:0];

   // 16 * row + col
   assign pix_offs = bmp_addr_t'({row, col});

   // a miss reads the null sprite, so it comes back as a 0 pixel
   assign rd_addr = hit ? bmp_addr_t'(attr.base + pix_offs) : NULL_ADDR;

   sprite_bitmap_ram u_bitmap (
      .clk     (clk),
      .rd_en   (q_valid),
      .rd_addr (rd_addr),
      .rd_data (unit_pix),       // registered, lines up with unit_valid
      .wr_en   (bmp_wr_en),
      .wr_addr (bmp_wr_addr),
      .wr_data (bmp_wr_data)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         unit_valid <= 1'b0;
      end else begin
         unit_valid <= q_valid;   // same stage as the ram read
      end
   end

endmodule
